/* rv_frontend_cfg.svh */
`ifndef RV_FRONTEND_CFG_SVH
`define RV_FRONTEND_CFG_SVH

// APB address width of the fetch requester
`define RVF_ADDR_W 32

// Address of the first fetch after reset
`define RVF_RESET_PC 32'h0000_0000

// Byte step between sequential instruction words
`define RVF_PC_STEP 4

`endif

/* rv_frontend_pkg.sv */
package rv_frontend_pkg;

   // Major opcode field, instruction bits 6:2
   typedef enum logic [4:0] {
      OPC_LOAD   = 5'b00000,
      OPC_OP_IMM = 5'b00100,
      OPC_AUIPC  = 5'b00101,
      OPC_STORE  = 5'b01000,
      OPC_OP     = 5'b01100,
      OPC_LUI    = 5'b01101,
      OPC_BRANCH = 5'b11000,
      OPC_JALR   = 5'b11001,
      OPC_JAL    = 5'b11011,
      OPC_SYSTEM = 5'b11100
   } opc_e;

   // Writable scratch-type machine CSRs
   typedef enum logic [1:0] {
      CSR_MTVEC    = 2'd0,
      CSR_MSCRATCH = 2'd1,
      CSR_MEPC     = 2'd2,
      CSR_MTVAL    = 2'd3
   } csr_addr_e;

   // One-hot ALU result select
   typedef enum logic [3:0] {
      ALU_RD_ADD   = 4'b0001,
      ALU_RD_SHIFT = 4'b0010,
      ALU_RD_SLT   = 4'b0100,
      ALU_RD_BOOL  = 4'b1000
   } alu_rd_sel_e;

   // Immediate layout selected by the decoder
   typedef enum logic [3:0] {
      IMM_FMT_I = 4'd0,
      IMM_FMT_S = 4'd1,
      IMM_FMT_B = 4'd2,
      IMM_FMT_U = 4'd3,
      IMM_FMT_J = 4'd4
   } imm_fmt_t;

endpackage

/* rv_fetch.sv */
`timescale 1ns/1ns
`include "rv_frontend_cfg.svh"

module rv_fetch #(
   parameter int ADDR_W = `RVF_ADDR_W
) (
   input  logic              clk,
   input  logic              i_arst_n,
   // APB requester, read only
   output logic              o_psel,
   output logic              o_penable,
   output logic [ADDR_W-1:0] o_paddr,
   input  logic [31:0]       i_prdata,
   input  logic              i_pready,
   input  logic              i_pslverr,
   // Instruction strobe toward decode
   output logic              o_ins_en,
   output logic [31:0]       o_ins_word,
   // Consumer handshake
   output logic              o_valid,
   input  logic              i_accept,
   output logic              o_fetch_err
);

   typedef enum logic [1:0] {
      ST_SETUP,
      ST_ACCESS,
      ST_STROBE,
      ST_HOLD
   } state_t;

   state_t            state;
   logic [ADDR_W-1:0] pc;
   logic [31:0]       ins_q;

   // Reset parks in HOLD with nothing valid, so the first
   // setup phase follows on the next clock
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         state       <= ST_HOLD;
         pc          <= ADDR_W'(`RVF_RESET_PC);
         o_valid     <= 1'b0;
         o_fetch_err <= 1'b0;
      end else begin
         case (state)
            ST_SETUP: begin
               state <= ST_ACCESS;
            end
            ST_ACCESS: begin
               if (i_pready) begin
                  state <= ST_STROBE;
                  // Sticky until reset
                  if (i_pslverr) begin
                     o_fetch_err <= 1'b1;
                  end
               end
            end
            ST_STROBE: begin
               state   <= ST_HOLD;
               o_valid <= 1'b1;
            end
            default: begin
               if (!o_valid) begin
                  state <= ST_SETUP;
               end else if (i_accept) begin
                  o_valid <= 1'b0;
                  pc      <= pc + ADDR_W'(`RVF_PC_STEP);
                  state   <= ST_SETUP;
               end
            end
         endcase
      end
   end

   // Read data capture on the completing access cycle
   always_ff @(posedge clk) begin
      if (state == ST_ACCESS && i_pready) begin
         ins_q <= i_prdata;
      end
   end

   assign o_psel     = (state == ST_SETUP) || (state == ST_ACCESS);
   assign o_penable  = (state == ST_ACCESS);
   assign o_paddr    = pc;
   assign o_ins_en   = (state == ST_STROBE);
   assign o_ins_word = ins_q;

   // Address may not move until the access completes
   a_paddr_stable: assert property (@(posedge clk) disable iff (!i_arst_n)
      (o_psel && !(o_penable && i_pready)) |=> $stable(o_paddr));

   // Access phase only inside a selected transfer that began with setup
   a_penable_psel: assert property (@(posedge clk) disable iff (!i_arst_n)
      o_penable |-> (o_psel && $past(o_psel)));

endmodule

/* rv_decode.sv */
`timescale 1ns/1ns

module rv_decode (
   input  logic                      clk,
   input  logic [31:2]               i_ins_word,
   input  logic                      i_ins_en,
   // Register file
   output logic [4:0]                o_rd_addr,
   output logic [4:0]                o_rs1_addr,
   output logic [4:0]                o_rs2_addr,
   // Operation classes
   output logic                      o_mem_op,
   output logic                      o_branch_op,
   output logic                      o_shift_op,
   output logic                      o_slt_op,
   output logic                      o_rd_op,
   output logic                      o_e_op,
   output logic                      o_ebreak,
   // Control
   output logic                      o_mret,
   output logic                      o_cond_branch,
   output logic                      o_jal_or_jalr,
   output logic                      o_utype,
   output logic                      o_pc_rel,
   // ALU
   output logic                      o_alu_sub,
   output logic [1:0]                o_alu_bool_op,
   output logic [3:0]                o_alu_rd_sel,
   output logic                      o_alu_sh_right,
   output logic                      o_alu_sh_signed,
   // Memory interface
   output logic                      o_mem_cmd,
   output logic                      o_mem_signed,
   output logic                      o_mem_word,
   output logic                      o_mem_half,
   // CSR
   output logic                      o_csr_en,
   output logic [1:0]                o_csr_addr,
   output logic                      o_rd_csr_en,
   // Operand and immediate steering
   output logic                      o_op_b_source,
   output rv_frontend_pkg::imm_fmt_t o_imm_fmt
);

   logic [4:0] opcode;
   logic [2:0] funct3;
   logic       op20;
   logic       op21;
   logic       op22;
   logic       op26;
   logic       op30;

   logic is_load;
   logic is_store;
   logic is_opimm;
   logic is_op;
   logic is_lui;
   logic is_auipc;
   logic is_branch;
   logic is_jal;
   logic is_jalr;
   logic is_system;
   logic op_or_opimm;
   logic csr_op;
   logic csr_valid;
   logic writes_rd;

   always_ff @(posedge clk) begin
      if (i_ins_en) begin
         opcode     <= i_ins_word[6:2];
         funct3     <= i_ins_word[14:12];
         op20       <= i_ins_word[20];
         op21       <= i_ins_word[21];
         op22       <= i_ins_word[22];
         op26       <= i_ins_word[26];
         op30       <= i_ins_word[30];
         o_rd_addr  <= i_ins_word[11:7];
         o_rs1_addr <= i_ins_word[19:15];
         o_rs2_addr <= i_ins_word[24:20];
      end
   end

   assign is_load   = (opcode == rv_frontend_pkg::OPC_LOAD);
   assign is_store  = (opcode == rv_frontend_pkg::OPC_STORE);
   assign is_opimm  = (opcode == rv_frontend_pkg::OPC_OP_IMM);
   assign is_op     = (opcode == rv_frontend_pkg::OPC_OP);
   assign is_lui    = (opcode == rv_frontend_pkg::OPC_LUI);
   assign is_auipc  = (opcode == rv_frontend_pkg::OPC_AUIPC);
   assign is_branch = (opcode == rv_frontend_pkg::OPC_BRANCH);
   assign is_jal    = (opcode == rv_frontend_pkg::OPC_JAL);
   assign is_jalr   = (opcode == rv_frontend_pkg::OPC_JALR);
   assign is_system = (opcode == rv_frontend_pkg::OPC_SYSTEM);

   assign op_or_opimm = is_op | is_opimm;

   assign o_mem_op    = is_load | is_store;
   assign o_branch_op = is_branch | is_jal | is_jalr;
   assign o_shift_op  = op_or_opimm & (funct3[1:0] == 2'b01);
   assign o_slt_op    = op_or_opimm & (funct3[2:1] == 2'b01);

   // ECALL and EBREAK; MRET has bit 21 set
   assign o_e_op   = is_system & (funct3 == 3'b000) & !op21;
   assign o_ebreak = o_e_op & op20;
   assign o_mret   = is_system & (funct3 == 3'b000) & op21;

   assign o_cond_branch = is_branch;
   assign o_jal_or_jalr = is_jal | is_jalr;
   assign o_utype       = is_lui | is_auipc;
   // Targets relative to the PC: JAL, branches, AUIPC
   assign o_pc_rel      = is_jal | is_branch | is_auipc;

   // No write for STORE, BRANCH, FENCE or x0
   assign writes_rd = is_load | is_opimm | is_auipc | is_op | is_lui |
                      is_jal | is_jalr | is_system;
   assign o_rd_op   = writes_rd & (o_rd_addr != 5'd0);

   // Compares need the subtractor too
   assign o_alu_sub = is_branch | o_slt_op | (is_op & (funct3 == 3'b000) & op30);
   assign o_alu_bool_op   = funct3[1:0];
   assign o_alu_sh_right  = funct3[2];
   assign o_alu_sh_signed = op30;

   // One equation per result select bit
   assign o_alu_rd_sel[0] = (funct3 == 3'b000);
   assign o_alu_rd_sel[1] = (funct3[1:0] == 2'b01);
   assign o_alu_rd_sel[2] = (funct3[2:1] == 2'b01);
   // XOR, OR and AND; funct3 101 is a shift
   assign o_alu_rd_sel[3] = funct3[2] & (funct3[1:0] != 2'b01);

   assign o_mem_cmd    = is_store;
   assign o_mem_signed = !funct3[2];
   assign o_mem_word   = funct3[1];
   assign o_mem_half   = funct3[0];

   // CSR number bits 0, 1, 2 and 6 sit at word bits 20, 21, 22 and 26
   //   mtvec 305, mscratch 340, mepc 341, mtval 343
   // mstatus, mie, mcause and mip fall outside csr_valid
   assign csr_op      = is_system & (funct3 != 3'b000);
   assign csr_valid   = op20 | (op26 & !op22 & !op21);
   assign o_rd_csr_en = csr_op;
   assign o_csr_en    = csr_op & csr_valid;

   always_comb begin
      if (op26 && !op20) begin
         o_csr_addr = rv_frontend_pkg::CSR_MSCRATCH;
      end else if (op26 && !op21) begin
         o_csr_addr = rv_frontend_pkg::CSR_MEPC;
      end else if (op26) begin
         o_csr_addr = rv_frontend_pkg::CSR_MTVAL;
      end else begin
         o_csr_addr = rv_frontend_pkg::CSR_MTVEC;
      end
   end

   // Second operand from rs2 for OP, BRANCH and STORE
   assign o_op_b_source = is_op | is_branch | is_store;

   always_comb begin
      case (opcode)
         rv_frontend_pkg::OPC_STORE:  o_imm_fmt = rv_frontend_pkg::IMM_FMT_S;
         rv_frontend_pkg::OPC_BRANCH: o_imm_fmt = rv_frontend_pkg::IMM_FMT_B;
         rv_frontend_pkg::OPC_LUI:    o_imm_fmt = rv_frontend_pkg::IMM_FMT_U;
         rv_frontend_pkg::OPC_AUIPC:  o_imm_fmt = rv_frontend_pkg::IMM_FMT_U;
         rv_frontend_pkg::OPC_JAL:    o_imm_fmt = rv_frontend_pkg::IMM_FMT_J;
         default:                     o_imm_fmt = rv_frontend_pkg::IMM_FMT_I;
      endcase
   end

   // Result select decoded from a freshly latched word is one-hot or empty
   a_rd_sel_onehot: assert property (@(posedge clk)
      $past(i_ins_en) |-> $onehot0(o_alu_rd_sel));

endmodule

/* rv_immdec.sv */
`timescale 1ns/1ns

module rv_immdec (
   input  logic                      clk,
   input  logic [31:7]               i_ins_word,
   input  logic                      i_ins_en,
   input  rv_frontend_pkg::imm_fmt_t i_imm_fmt,
   output logic [31:0]               o_imm
);

   logic        sign;
   logic [30:20] hi;
   logic [19:12] mid;
   logic [11:7]  lo;

   // Every bit from 31 down to 7 lands in some format
   always_ff @(posedge clk) begin
      if (i_ins_en) begin
         sign <= i_ins_word[31];
         hi   <= i_ins_word[30:20];
         mid  <= i_ins_word[19:12];
         lo   <= i_ins_word[11:7];
      end
   end

   always_comb begin
      case (i_imm_fmt)
         rv_frontend_pkg::IMM_FMT_S: begin
            o_imm = {{21{sign}}, hi[30:25], lo[11:7]};
         end
         // Branch offset, bit 0 always clear
         rv_frontend_pkg::IMM_FMT_B: begin
            o_imm = {{20{sign}}, lo[7], hi[30:25], lo[11:8], 1'b0};
         end
         // Upper immediate, low 12 bits zero
         rv_frontend_pkg::IMM_FMT_U: begin
            o_imm = {sign, hi[30:20], mid[19:12], 12'h000};
         end
         rv_frontend_pkg::IMM_FMT_J: begin
            o_imm = {{12{sign}}, mid[19:12], hi[20], hi[30:21], 1'b0};
         end
         default: begin
            o_imm = {{21{sign}}, hi[30:20]};
         end
      endcase
   end

endmodule

/* rv_frontend_top.sv */
`timescale 1ns/1ns
`include "rv_frontend_cfg.svh"

module rv_frontend_top (
   input  logic                   clk,
   input  logic                   i_arst_n,
   // APB requester, reads only
   output logic                   o_psel,
   output logic                   o_penable,
   output logic [`RVF_ADDR_W-1:0] o_paddr,
   input  logic [31:0]            i_prdata,
   input  logic                   i_pready,
   input  logic                   i_pslverr,
   // Toward execute
   output logic                   o_dec_valid,
   input  logic                   i_dec_ready,
   output logic                   o_fetch_err,
   output logic [4:0]             o_rd_addr,
   output logic [4:0]             o_rs1_addr,
   output logic [4:0]             o_rs2_addr,
   output logic                   o_mem_op,
   output logic                   o_branch_op,
   output logic                   o_shift_op,
   output logic                   o_slt_op,
   output logic                   o_rd_op,
   output logic                   o_e_op,
   output logic                   o_ebreak,
   output logic                   o_mret,
   output logic                   o_cond_branch,
   output logic                   o_jal_or_jalr,
   output logic                   o_utype,
   output logic                   o_pc_rel,
   output logic                   o_alu_sub,
   output logic [1:0]             o_alu_bool_op,
   output logic [3:0]             o_alu_rd_sel,
   output logic                   o_alu_sh_right,
   output logic                   o_alu_sh_signed,
   output logic                   o_mem_cmd,
   output logic                   o_mem_signed,
   output logic                   o_mem_word,
   output logic                   o_mem_half,
   output logic                   o_csr_en,
   output logic [1:0]             o_csr_addr,
   output logic                   o_rd_csr_en,
   output logic                   o_op_b_source,
   output logic [31:0]            o_imm
);

   logic                      ins_en;
   logic [31:0]               ins_word;
   rv_frontend_pkg::imm_fmt_t imm_fmt;

   // PWRITE stays low on the bus, the requester never writes
   rv_fetch #(
      .ADDR_W (`RVF_ADDR_W)
   ) u_fetch (
      .clk         (clk),
      .i_arst_n    (i_arst_n),
      .o_psel      (o_psel),
      .o_penable   (o_penable),
      .o_paddr     (o_paddr),
      .i_prdata    (i_prdata),
      .i_pready    (i_pready),
      .i_pslverr   (i_pslverr),
      .o_ins_en    (ins_en),
      .o_ins_word  (ins_word),
      .o_valid     (o_dec_valid),
      .i_accept    (i_dec_ready),
      .o_fetch_err (o_fetch_err)
   );

   rv_decode u_decode (
      .clk             (clk),
      .i_ins_word      (ins_word[31:2]),
      .i_ins_en        (ins_en),
      .o_rd_addr       (o_rd_addr),
      .o_rs1_addr      (o_rs1_addr),
      .o_rs2_addr      (o_rs2_addr),
      .o_mem_op        (o_mem_op),
      .o_branch_op     (o_branch_op),
      .o_shift_op      (o_shift_op),
      .o_slt_op        (o_slt_op),
      .o_rd_op         (o_rd_op),
      .o_e_op          (o_e_op),
      .o_ebreak        (o_ebreak),
      .o_mret          (o_mret),
      .o_cond_branch   (o_cond_branch),
      .o_jal_or_jalr   (o_jal_or_jalr),
      .o_utype         (o_utype),
      .o_pc_rel        (o_pc_rel),
      .o_alu_sub       (o_alu_sub),
      .o_alu_bool_op   (o_alu_bool_op),
      .o_alu_rd_sel    (o_alu_rd_sel),
      .o_alu_sh_right  (o_alu_sh_right),
      .o_alu_sh_signed (o_alu_sh_signed),
      .o_mem_cmd       (o_mem_cmd),
      .o_mem_signed    (o_mem_signed),
      .o_mem_word      (o_mem_word),
      .o_mem_half      (o_mem_half),
      .o_csr_en        (o_csr_en),
      .o_csr_addr      (o_csr_addr),
      .o_rd_csr_en     (o_rd_csr_en),
      .o_op_b_source   (o_op_b_source),
      .o_imm_fmt       (imm_fmt)
   );

   rv_immdec u_immdec (
      .clk        (clk),
      .i_ins_word (ins_word[31:7]),
      .i_ins_en   (ins_en),
      .i_imm_fmt  (imm_fmt),
      .o_imm      (o_imm)
   );

endmodule

/* tb_rv_frontend.sv */
`timescale 1ns/1ns
`include "rv_frontend_cfg.svh"

module tb_rv_frontend;

   localparam int N_MAX         = 32;
   localparam int VALID_TIMEOUT = 50;

   logic        clk         = 1'b0;
   logic        i_arst_n    = 1'b0;
   logic [31:0] i_prdata    = 32'h0;
   logic        i_pready    = 1'b0;
   logic        i_pslverr   = 1'b0;
   logic        i_dec_ready = 1'b0;

   logic                   o_psel, o_penable, o_dec_valid, o_fetch_err;
   logic [`RVF_ADDR_W-1:0] o_paddr;
   logic [4:0]             o_rd_addr, o_rs1_addr, o_rs2_addr;
   logic                   o_mem_op, o_branch_op, o_shift_op, o_slt_op, o_rd_op;
   logic                   o_e_op, o_ebreak, o_mret, o_cond_branch, o_jal_or_jalr;
   logic                   o_utype, o_pc_rel, o_alu_sub, o_alu_sh_right, o_alu_sh_signed;
   logic                   o_mem_cmd, o_mem_signed, o_mem_word, o_mem_half;
   logic                   o_csr_en, o_rd_csr_en, o_op_b_source;
   logic [1:0]             o_alu_bool_op, o_csr_addr;
   logic [3:0]             o_alu_rd_sel;
   logic [31:0]            o_imm;

   // Instruction table, expected class fields, random wait and stall lengths
   logic [31:0] ins [N_MAX];
   int          exp_f [N_MAX][11];
   int          wait_cnt [N_MAX];
   int          stall_cnt [N_MAX];
   int          n_cases = 0;

   int   seed      = 74123;
   int   n_err     = 0;
   int   n_other   = 0;
   int   n_acc     = 0;
   int   n_fetch   = 0;
   int   wait_left = 0;
   logic err_now   = 1'b0;
   logic prev_psel = 1'b0;
   logic err_seen  = 1'b0;
   logic abort     = 1'b0;

   rv_frontend_top dut0 (.*);

   always #2 clk = ~clk;

   task automatic check(input int got, input int want, input string what);
      if (got !== want) begin
         n_err++;
         $display("** Error: %0t ns: %s: got %0h, expected %0h", $time, what, got, want);
      end
   endtask

   // Immediate of the base RV32I formats, chosen by the 7-bit opcode
   function automatic logic [31:0] ref_imm(input logic [31:0] w);
      case (w[6:0])
         7'h23:        return {{20{w[31]}}, w[31:25], w[11:7]};
         7'h63:        return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
         7'h37, 7'h17: return {w[31:12], 12'h000};
         7'h6F:        return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
         default:      return {{20{w[31]}}, w[31:20]};
      endcase
   endfunction

   function automatic string opname(input logic [31:0] w);
      rv_frontend_pkg::opc_e op;
      op = rv_frontend_pkg::opc_e'(w[6:2]);
      return op.name();
   endfunction

   function automatic logic [127:0] decoded_snapshot();
      return 128'({o_rd_addr, o_rs1_addr, o_rs2_addr, o_mem_op, o_branch_op, o_shift_op,
                   o_slt_op, o_rd_op, o_e_op, o_ebreak, o_mret, o_cond_branch,
                   o_jal_or_jalr, o_utype, o_pc_rel, o_alu_sub, o_alu_bool_op,
                   o_alu_rd_sel, o_alu_sh_right, o_alu_sh_signed, o_mem_cmd,
                   o_mem_signed, o_mem_word, o_mem_half, o_csr_en, o_csr_addr,
                   o_rd_csr_en, o_op_b_source, o_imm});
   endfunction

   task automatic load_cases();
      int    fd;
      int    cnt;
      string line;
      fd = $fopen("rv_frontend_cases.txt", "r");
      if (fd == 0) begin
         $display("Cannot open the cases file rv_frontend_cases.txt");
         n_other++;
         return;
      end
      while (!$feof(fd) && n_cases < N_MAX) begin
         cnt = $fgets(line, fd);
         if (cnt > 1 && line[0] != "#") begin
            cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h", ins[n_cases],
                          exp_f[n_cases][0], exp_f[n_cases][1], exp_f[n_cases][2],
                          exp_f[n_cases][3], exp_f[n_cases][4], exp_f[n_cases][5],
                          exp_f[n_cases][6], exp_f[n_cases][7], exp_f[n_cases][8],
                          exp_f[n_cases][9], exp_f[n_cases][10]);
            if (cnt == 12) begin
               wait_cnt[n_cases]  = $random(seed) & 3;
               stall_cnt[n_cases] = $random(seed) & 3;
               n_cases++;
            end
         end
      end
      $fclose(fd);
      if (n_cases == 0) begin
         $display("No instructions were read from the cases file");
         n_other++;
      end
   endtask

   task automatic wait_valid(input int k);
      int t;
      t = 0;
      @(posedge clk);
      while (!o_dec_valid && t < VALID_TIMEOUT) begin
         @(posedge clk);
         t++;
      end
      if (!o_dec_valid) begin
         $display("Timed out waiting for decoded instruction %0d", k);
         n_other++;
         abort = 1'b1;
      end
   endtask

   task automatic check_case(input int k);
      logic [31:0] w;
      string       tag;
      w   = ins[k];
      tag = $sformatf("#%0d %s", k, opname(w));
      check(int'(o_rd_addr), int'(w[11:7]), {tag, " rd"});
      check(int'(o_rs1_addr), int'(w[19:15]), {tag, " rs1"});
      check(int'(o_rs2_addr), int'(w[24:20]), {tag, " rs2"});
      // No register write for stores, branches or x0
      check(int'(o_rd_op), int'(w[6:0] != 7'h23 && w[6:0] != 7'h63 && w[11:7] != 5'd0),
            {tag, " rd_op"});
      check(int'(o_imm), int'(ref_imm(w)), {tag, " imm"});
      check(int'(o_mem_op), exp_f[k][0], {tag, " mem_op"});
      check(int'(o_branch_op), exp_f[k][1], {tag, " branch_op"});
      check(int'(o_shift_op), exp_f[k][2], {tag, " shift_op"});
      check(int'(o_slt_op), exp_f[k][3], {tag, " slt_op"});
      check(int'(o_mem_word), exp_f[k][4], {tag, " mem_word"});
      check(int'(o_mem_half), exp_f[k][5], {tag, " mem_half"});
      check(int'(o_mem_signed), exp_f[k][6], {tag, " mem_signed"});
      check(int'(o_alu_sub), exp_f[k][7], {tag, " alu_sub"});
      check(int'(o_alu_rd_sel), exp_f[k][8], {tag, " alu_rd_sel"});
      check(int'(o_csr_addr), exp_f[k][9], {tag, " csr_addr"});
      check(int'(o_fetch_err), int'(err_seen), {tag, " fetch_err"});
   endtask

   // Back-pressure for a random stretch, then a single accept cycle
   task automatic hold_and_accept(input int k);
      logic [127:0] held;
      held = decoded_snapshot();
      repeat (stall_cnt[k]) begin
         @(posedge clk);
         check(int'(o_dec_valid), 1, "valid under back-pressure");
         check(int'(held == decoded_snapshot()), 1, "outputs hold under back-pressure");
      end
      i_dec_ready <= 1'b1;
      @(posedge clk);
      check(int'(held == decoded_snapshot()), 1, "outputs at accept");
      i_dec_ready <= 1'b0;
      n_acc++;
   endtask

   // APB completer with wait states, plus bus protocol checks
   always @(posedge clk) begin
      if (i_arst_n) begin
         check(int'(!o_penable || (o_psel && prev_psel)), 1, "PENABLE after a setup cycle");
         check(int'(!(o_psel && o_dec_valid)), 1, "no fetch while an instruction is held");
         if (o_psel && !o_penable) begin
            check(int'(o_paddr), int'(`RVF_RESET_PC + `RVF_PC_STEP * n_acc), "APB address");
            check(n_fetch, n_acc, "one fetch per accepted instruction");
            wait_left = (n_fetch < n_cases) ? wait_cnt[n_fetch] : 0;
            err_now   = (n_fetch < n_cases) && (exp_f[n_fetch][10] != 0);
            i_prdata  <= (n_fetch < n_cases) ? ins[n_fetch] : 32'h0;
            i_pready  <= (wait_left == 0);
            i_pslverr <= err_now && (wait_left == 0);
         end else if (o_penable && i_pready) begin
            i_pready  <= 1'b0;
            i_pslverr <= 1'b0;
            n_fetch++;
         end else if (o_penable) begin
            wait_left--;
            i_pready  <= (wait_left == 0);
            i_pslverr <= err_now && (wait_left == 0);
         end
      end
      prev_psel = o_psel;
   end

   initial begin
      load_cases();
      repeat (8) @(posedge clk);
      i_arst_n <= 1'b1;
      for (int k = 0; k < n_cases && !abort; k++) begin
         wait_valid(k);
         if (!abort) begin
            err_seen = err_seen || (exp_f[k][10] != 0);
            check_case(k);
            hold_and_accept(k);
         end
      end
      check(n_acc, n_cases, "accepted instruction count");
      check(int'(o_fetch_err), int'(err_seen), "fetch error flag at end of run");
      $display("Checked %0d instructions: %0d mismatches, %0d other failures",
               n_acc, n_err, n_other);
      if (n_err == 0 && n_other == 0 && n_cases > 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

/* rv_frontend_cases.txt */
# word     mem br sh slt word half sgn sub rdsel csr err   (all hex)
# err = 1 makes the APB completer answer that fetch with PSLVERR
003100B3 0 0 0 0 0 0 1 0 1 0 0   # add   x1, x2, x3
407302B3 0 0 0 0 0 0 1 1 1 0 0   # sub   x5, x6, x7
00A49433 0 0 1 0 0 1 1 0 2 0 0   # sll   x8, x9, x10
40365593 0 0 1 0 0 1 0 0 2 0 0   # srai  x11, x12, 3
FFB72693 0 0 0 1 1 0 1 1 4 3 0   # slti  x13, x14, -5
011837B3 0 0 0 1 1 1 1 1 4 0 0   # sltu  x15, x16, x17
0089A903 1 0 0 0 1 0 1 0 4 0 1   # lw    x18, 8(x19)
FFEADA03 1 0 0 0 0 1 0 0 2 1 0   # lhu   x20, -2(x21)
016BA623 1 0 0 0 1 0 1 0 4 0 0   # sw    x22, 12(x23)
FE208CE3 0 1 0 0 0 0 1 1 1 1 0   # beq   x1, x2, -8
001000EF 0 1 0 0 0 0 1 0 1 0 0   # jal   x1, 2048
00008067 0 1 0 0 0 0 1 0 1 0 0   # jalr  x0, 0(x1)
123452B7 0 0 0 0 0 1 0 0 2 0 0   # lui   x5, 0x12345
FFFFF317 0 0 0 0 1 1 0 0 8 3 0   # auipc x6, 0xfffff
340413F3 0 0 0 0 0 1 1 0 2 1 0   # csrrw  x7, mscratch, x8
341024F3 0 0 0 0 1 0 1 0 4 2 0   # csrrs  x9, mepc, x0
3435B573 0 0 0 0 1 1 1 0 4 3 0   # csrrc  x10, mtval, x11
3052D673 0 0 0 0 0 1 0 0 2 0 0   # csrrwi x12, mtvec, 5
00000073 0 0 0 0 0 0 1 0 1 0 0   # ecall
30200073 0 0 0 0 0 0 1 0 1 0 0   # mret

/* vlog.f */
+incdir+.
rv_frontend_pkg.sv
rv_fetch.sv
rv_decode.sv
rv_immdec.sv
rv_frontend_top.sv
tb_rv_frontend.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rv_frontend
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep '\.sv$$' $(FILELIST)) rv_frontend_cfg.svh
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the simulation prints the pass line
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q '^RESULT: PASS$$'

clean:
	rm -rf $(OBJ_DIR)
